//--- hw/cmp_pkg.sv
// Wide magnitude comparator shared definitions
// Operation codes, carry and slice-count types, and the width helpers
// used to size the slice and carry logic
package cmp_pkg;

    // Operation code presented with each pair of operands
    typedef logic [1:0] op_t;

    // Greater-than and greater-or-equal are the native forms.
    // The other two are reached by swapping the operands
    localparam op_t OP_GT = 2'd0;
    localparam op_t OP_GE = 2'd1;
    localparam op_t OP_LT = 2'd2;
    localparam op_t OP_LE = 2'd3;

    // One bit of the lookahead carry chain
    typedef logic carry_t;

    // Counts of bits and slices used when sizing the chunk logic
    typedef int unsigned chunk_cnt_t;

    // Common width that both operands are extended to
    function automatic chunk_cnt_t common_width(
        input chunk_cnt_t a_width,
        input chunk_cnt_t b_width
    );
        return (a_width > b_width) ? a_width : b_width;
    endfunction

    // Number of CHUNK-bit slices needed to cover the common width.
    // The top slice holds the remainder when the width does not divide evenly
    function automatic chunk_cnt_t lcu_slices(
        input chunk_cnt_t width,
        input chunk_cnt_t chunk
    );
        return (width + chunk - 1) / chunk;
    endfunction

endpackage

//--- hw/cmp_pg_if.sv
// Slice propagate/generate bus between the chunk stage and the carry unit
// Carries one propagate and one generate bit per slice, the carry-in
// and the valid bit of the operation in flight
interface cmp_pg_if #(
    parameter int SLICES = 1
);
    import cmp_pkg::*;

    // High where the slice of A equals the slice of B
    logic [SLICES-1:0] p;
    // High where the slice alone decides A > B
    logic [SLICES-1:0] g;
    // Carry into the bottom slice, set for the or-equal forms
    carry_t            ci;
    // Marks a cycle that carries an operation
    logic              valid;

    // Chunk stage side
    modport source (
        output p, g, ci, valid
    );

    // Carry unit side
    modport sink (
        input p, g, ci, valid
    );

endinterface

//--- hw/cmp_operand_stage.sv
// Comparator operand stage
// Folds less-than forms into greater-than forms by swapping the operands,
// extends both to the common width and picks the carry-in, one cycle
module cmp_operand_stage #(
    parameter int A_WIDTH = 32,
    parameter int B_WIDTH = 24
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           in_valid,
    input  logic [A_WIDTH-1:0]                             a,
    input  logic [B_WIDTH-1:0]                             b,
    input  cmp_pkg::op_t                                   op,
    input  logic                                           signed_mode,
    output logic                                           stage_valid,
    output logic [cmp_pkg::common_width(A_WIDTH, B_WIDTH)-1:0] aa,
    output logic [cmp_pkg::common_width(A_WIDTH, B_WIDTH)-1:0] bb,
    output cmp_pkg::carry_t                                ci,
    output logic                                           signed_q
);
    import cmp_pkg::*;

    localparam int WIDTH = common_width(A_WIDTH, B_WIDTH);

    // An operand after extension to the common width
    typedef logic [WIDTH-1:0] word_t;

    word_t  a_ext;
    word_t  b_ext;
    logic   swap;
    carry_t ci_next;

    // Signed mode replicates each operand's own top bit.
    // Unsigned mode pads with zeros
    assign a_ext = signed_mode ? word_t'($signed(a)) : word_t'(a);
    assign b_ext = signed_mode ? word_t'($signed(b)) : word_t'(b);

    // A < B is B > A, and A <= B is B >= A
    assign swap = (op == OP_LT) || (op == OP_LE);

    // The or-equal forms start the chain with a carry so that
    // a fully equal pair still comes out true
    assign ci_next = (op == OP_GE) || (op == OP_LE);

    // Only the valid bit is control state
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    // Operand payload, loaded every cycle
    always_ff @(posedge clk) begin
        aa       <= swap ? b_ext : a_ext;
        bb       <= swap ? a_ext : b_ext;
        ci       <= ci_next;
        signed_q <= signed_mode;
    end

    // An operation entering the pipe must carry a defined op code,
    // since the swap and the carry-in both depend on it
    assert property (@(posedge clk) disable iff (reset)
        in_valid |-> !$isunknown(op))
        else $error("op is unknown while in_valid is high");

endmodule

//--- hw/cmp_chunk_pg.sv
// Comparator chunk stage
// Splits the extended operands into CHUNK-bit slices and computes a
// propagate bit (slice equal) and a generate bit (slice says A > B) per slice
module cmp_chunk_pg #(
    parameter int A_WIDTH = 32,
    parameter int B_WIDTH = 24,
    parameter int CHUNK   = 3
) (
    input  logic [cmp_pkg::common_width(A_WIDTH, B_WIDTH)-1:0] aa,
    input  logic [cmp_pkg::common_width(A_WIDTH, B_WIDTH)-1:0] bb,
    input  cmp_pkg::carry_t                                ci,
    input  logic                                           signed_q,
    input  logic                                           stage_valid,
    cmp_pg_if.source                                       pg
);
    import cmp_pkg::*;

    localparam int WIDTH  = common_width(A_WIDTH, B_WIDTH);
    localparam int SLICES = lcu_slices(WIDTH, CHUNK);

    for (genvar s = 0; s < SLICES; s++) begin : g_slice
        // Bit range covered by this slice.
        // The top slice is narrower when CHUNK does not divide the width
        localparam int  LO  = s * CHUNK;
        localparam int  SW  = ((WIDTH - LO) < CHUNK) ? (WIDTH - LO) : CHUNK;
        localparam bit  TOP = (s == SLICES - 1);

        logic [SW-1:0] eq;
        logic [SW-1:0] hit;
        logic          p_s;
        logic          g_s;

        always_comb begin
            logic above_eq;

            // Bitwise equality of the two slices
            eq = aa[LO +: SW] ~^ bb[LO +: SW];

            // A bit favours A when A has a one where B has a zero
            for (int j = 0; j < SW; j++) begin
                hit[j] = aa[LO + j] & ~bb[LO + j];
            end

            // The sign bit weighs negative, so a one there means smaller
            if (TOP && signed_q) begin
                hit[SW-1] = ~aa[WIDTH-1] & bb[WIDTH-1];
            end

            // Priority scan from the top bit down.
            // A lower bit only counts while every bit above it is equal
            above_eq = 1'b1;
            g_s      = 1'b0;
            for (int j = SW - 1; j >= 0; j--) begin
                g_s      = g_s | (above_eq & hit[j]);
                above_eq = above_eq & eq[j];
            end

            // Equal slice leaves the decision to the slices below
            p_s = above_eq;
        end

        assign pg.p[s] = p_s;
        assign pg.g[s] = g_s;
    end

    // Carry-in and valid ride along with the slice bits
    assign pg.ci    = ci;
    assign pg.valid = stage_valid;

endmodule

//--- hw/cmp_lcu.sv
// Comparator lookahead carry unit
// Chains the slice generate and propagate bits from the carry-in upward
// and registers the top carry as the comparison result, one cycle
module cmp_lcu #(
    parameter int A_WIDTH = 32,
    parameter int B_WIDTH = 24,
    parameter int CHUNK   = 3
) (
    input  logic            clk,
    input  logic            reset,
    cmp_pg_if.sink          pg,
    output logic            out_valid,
    output cmp_pkg::carry_t result
);
    import cmp_pkg::*;

    localparam int WIDTH  = common_width(A_WIDTH, B_WIDTH);
    localparam int SLICES = lcu_slices(WIDTH, CHUNK);

    // Carry out of each slice
    logic [SLICES-1:0] co;

    // Each slice either decides on its own or passes the verdict
    // from below when it is equal
    always_comb begin
        co[0] = pg.g[0] | (pg.p[0] & pg.ci);
        for (int s = 1; s < SLICES; s++) begin
            co[s] = pg.g[s] | (pg.p[s] & co[s-1]);
        end
    end

    // The carry out of the top slice is the answer for the whole word
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            result    <= 1'b0;
        end else begin
            out_valid <= pg.valid;
            result    <= co[SLICES-1];
        end
    end

    // A reported result must be defined all the way from the operand
    // registers through the slice logic
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown(result))
        else $error("result is unknown while out_valid is high");

endmodule

//--- hw/wide_cmp_top.sv
// Pipelined wide magnitude comparator
// Compares a and b under op and signed_mode on a slice-and-carry structure
// Result follows its inputs by two cycles, one operation per cycle
module wide_cmp_top #(
    parameter int A_WIDTH = 32,
    parameter int B_WIDTH = 24,
    // Half the input count of a 6-input LUT
    parameter int CHUNK   = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  logic [A_WIDTH-1:0] a,
    input  logic [B_WIDTH-1:0] b,
    input  cmp_pkg::op_t       op,
    input  logic               signed_mode,
    output logic               out_valid,
    output logic               result
);
    import cmp_pkg::*;

    localparam int WIDTH  = common_width(A_WIDTH, B_WIDTH);
    localparam int SLICES = lcu_slices(WIDTH, CHUNK);

    // Registered operand stage outputs
    logic             stage_valid;
    logic [WIDTH-1:0] aa;
    logic [WIDTH-1:0] bb;
    carry_t           ci;
    logic             signed_q;

    // Slice bits from the chunk stage to the carry unit
    cmp_pg_if #(.SLICES(SLICES)) pg_bus ();

    cmp_operand_stage #(.A_WIDTH(A_WIDTH), .B_WIDTH(B_WIDTH)) u_operand (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .a          (a),
        .b          (b),
        .op         (op),
        .signed_mode(signed_mode),
        .stage_valid(stage_valid),
        .aa         (aa),
        .bb         (bb),
        .ci         (ci),
        .signed_q   (signed_q)
    );

    cmp_chunk_pg #(.A_WIDTH(A_WIDTH), .B_WIDTH(B_WIDTH), .CHUNK(CHUNK)) u_chunk (
        .aa(aa), .bb(bb), .ci(ci), .signed_q(signed_q), .stage_valid(stage_valid),
        .pg(pg_bus.source)
    );

    cmp_lcu #(.A_WIDTH(A_WIDTH), .B_WIDTH(B_WIDTH), .CHUNK(CHUNK)) u_lcu (
        .clk(clk), .reset(reset), .pg(pg_bus.sink), .out_valid(out_valid), .result(result)
    );

endmodule

//--- verif/tb_wide_cmp.sv
// Testbench for the pipelined wide magnitude comparator
// Applies a table of directed and random operations, one per clock, and
// checks each result and its latency against a reference model
module tb_wide_cmp;
    import cmp_pkg::*;

    localparam int A_WIDTH      = 32;
    localparam int B_WIDTH      = 24;
    localparam int CHUNK        = 3;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_DIRECTED   = 24;
    localparam int N_RANDOM     = 40;
    localparam int N_ROWS       = N_DIRECTED + N_RANDOM;

    logic               clk;
    logic               reset;
    logic               in_valid;
    logic [A_WIDTH-1:0] a;
    logic [B_WIDTH-1:0] b;
    op_t                op;
    logic               signed_mode;
    logic               out_valid;
    logic               result;

    // Stimulus table with the expected result of each row
    logic [A_WIDTH-1:0] a_tab   [N_ROWS];
    logic [B_WIDTH-1:0] b_tab   [N_ROWS];
    op_t                op_tab  [N_ROWS];
    logic               sm_tab  [N_ROWS];
    logic               exp_tab [N_ROWS];
    int                 n_filled;

    // Operations in flight, oldest first
    logic exp_q [$];
    int   row_q [$];
    int   due_q [$];

    int cycle;
    int n_results;

    wide_cmp_top #(.A_WIDTH(A_WIDTH), .B_WIDTH(B_WIDTH), .CHUNK(CHUNK)) UUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .a          (a),
        .b          (b),
        .op         (op),
        .signed_mode(signed_mode),
        .out_valid  (out_valid),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Counts rising edges, so after edge E it holds E
    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Reference model. Both operands are widened by one bit past the common
    // width so that a signed compare also orders unsigned values correctly
    function automatic logic compare_model(input logic [A_WIDTH-1:0] x,
                                           input logic [B_WIDTH-1:0] y,
                                           input op_t code, input logic sm);
        logic signed [A_WIDTH:0] sx;
        logic signed [A_WIDTH:0] sy;
        if (sm) begin
            sx = {x[A_WIDTH-1], x};
            sy = {{(A_WIDTH - B_WIDTH + 1){y[B_WIDTH-1]}}, y};
        end else begin
            sx = {1'b0, x};
            sy = {{(A_WIDTH - B_WIDTH + 1){1'b0}}, y};
        end
        case (code)
            OP_GT:   return sx > sy;
            OP_GE:   return sx >= sy;
            OP_LT:   return sx < sy;
            OP_LE:   return sx <= sy;
            default: return 1'b0;
        endcase
    endfunction

    task automatic add_row(input logic [A_WIDTH-1:0] x, input logic [B_WIDTH-1:0] y,
                           input op_t code, input logic sm, input logic expected);
        a_tab[n_filled]   = x;
        b_tab[n_filled]   = y;
        op_tab[n_filled]  = code;
        sm_tab[n_filled]  = sm;
        exp_tab[n_filled] = expected;
        n_filled++;
    endtask

    task automatic fill_random_rows();
        logic [31:0] r;
        logic [A_WIDTH-1:0] x;
        logic [B_WIDTH-1:0] y;
        r = 32'hc75c17f5;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = xorshift32(r);
            x = r;
            r = xorshift32(r);
            y = r[B_WIDTH-1:0];
            // Now and then make x the extended y so that the or-equal path is hit
            if (r[31:29] == 3'b000) begin
                x = r[26] ? {{(A_WIDTH - B_WIDTH){y[B_WIDTH-1]}}, y}
                          : {{(A_WIDTH - B_WIDTH){1'b0}}, y};
            end
            add_row(x, y, op_t'(r[25:24]), r[26], compare_model(x, y, op_t'(r[25:24]), r[26]));
        end
    endtask

    // Results are read on the falling edge, away from the register updates
    always @(negedge clk) begin
        if (out_valid) begin
            assert (exp_q.size() != 0)
                else stop_with_failure("out_valid went high with no operation in flight");
            assert (cycle == due_q[0])
                else stop_with_failure($sformatf("** Error at time %0t: row %0d came out %0s",
                    $time, row_q[0], "at the wrong cycle"));
            assert (result === exp_q[0])
                else stop_with_failure($sformatf("** Error at time %0t: row %0d result %b, %s %b",
                    $time, row_q[0], result, "expected", exp_q[0]));
            void'(exp_q.pop_front());
            void'(row_q.pop_front());
            void'(due_q.pop_front());
            n_results++;
        end
    end

    initial begin
        #((N_ROWS + 40) * CLK_PERIOD);
        stop_with_failure("Timeout: the run did not finish in the allowed number of cycles");
    end

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        a           = '0;
        b           = '0;
        op          = OP_GT;
        signed_mode = 1'b0;
        cycle       = 0;
        n_results   = 0;
        n_filled    = 0;

        // Equal operands, unsigned then signed
        add_row(32'h0012_3456, 24'h12_3456, OP_GE, 1'b0, 1'b1);
        add_row(32'h0012_3456, 24'h12_3456, OP_LE, 1'b0, 1'b1);
        add_row(32'h0012_3456, 24'h12_3456, OP_GT, 1'b0, 1'b0);
        add_row(32'h0012_3456, 24'h12_3456, OP_LT, 1'b0, 1'b0);
        add_row(32'hFFFF_FF80, 24'hFF_FF80, OP_GE, 1'b1, 1'b1);
        add_row(32'hFFFF_FF80, 24'hFF_FF80, OP_LE, 1'b1, 1'b1);
        add_row(32'hFFFF_FF80, 24'hFF_FF80, OP_GT, 1'b1, 1'b0);
        add_row(32'hFFFF_FF80, 24'hFF_FF80, OP_LT, 1'b1, 1'b0);
        // Unsigned, differing in the lowest bit, the highest bits and a middle slice
        add_row(32'h0000_0101, 24'h00_0100, OP_GT, 1'b0, 1'b1);
        add_row(32'h0000_0101, 24'h00_0100, OP_LT, 1'b0, 1'b0);
        add_row(32'h8000_0000, 24'h00_0000, OP_GT, 1'b0, 1'b1);
        add_row(32'h0000_0000, 24'h80_0000, OP_LT, 1'b0, 1'b1);
        add_row(32'h0001_2000, 24'h01_1000, OP_GE, 1'b0, 1'b1);
        add_row(32'h0001_2000, 24'h01_1000, OP_LE, 1'b0, 1'b0);
        // Negative against positive flips the unsigned answer
        add_row(32'h8000_0000, 24'h00_0001, OP_GT, 1'b1, 1'b0);
        add_row(32'h8000_0000, 24'h00_0001, OP_GT, 1'b0, 1'b1);
        add_row(32'hFFFF_FFFF, 24'h00_0000, OP_LT, 1'b1, 1'b1);
        add_row(32'hFFFF_FFFF, 24'h00_0000, OP_LT, 1'b0, 1'b0);
        add_row(32'h8000_0000, 24'h7F_FFFF, OP_LT, 1'b1, 1'b1);
        add_row(32'h8000_0000, 24'h7F_FFFF, OP_LT, 1'b0, 1'b0);
        // The narrower b is sign-extended only in signed mode
        add_row(32'h0000_0001, 24'h80_0000, OP_GT, 1'b1, 1'b1);
        add_row(32'h0000_0001, 24'h80_0000, OP_GT, 1'b0, 1'b0);
        add_row(32'hFF80_0000, 24'h80_0000, OP_LE, 1'b1, 1'b1);
        add_row(32'hFF80_0000, 24'h80_0000, OP_LE, 1'b0, 1'b0);
        fill_random_rows();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // Idle cycles so out_valid is seen to stay low after reset
        repeat (2) @(posedge clk);

        for (int i = 0; i < N_ROWS; i++) begin
            in_valid    <= 1'b1;
            a           <= a_tab[i];
            b           <= b_tab[i];
            op          <= op_tab[i];
            signed_mode <= sm_tab[i];
            exp_q.push_back(exp_tab[i]);
            row_q.push_back(i);
            // The count of this edge has not landed yet.
            // The result shows two edges after this one
            due_q.push_back(cycle + 3);
            @(posedge clk);
        end
        in_valid <= 1'b0;

        // Latency is fixed, so a few edges cover the result of the last row
        repeat (4) @(posedge clk);

        if (n_results == N_ROWS) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("Got %0d results for %0d operations", n_results, N_ROWS));
        end
    end

endmodule

//--- tb.f
hw/cmp_pkg.sv
hw/cmp_pg_if.sv
hw/cmp_operand_stage.sv
hw/cmp_chunk_pg.sv
hw/cmp_lcu.sv
hw/wide_cmp_top.sv
verif/tb_wide_cmp.sv

//--- Makefile
# Verilator build and run of the wide comparator testbench
# Any variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_wide_cmp
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
RUN_ARGS  ?=

# Sources come from the file list, so the binary is rebuilt when one changes
SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits with a failing status on $fatal
run: $(SIM)
	./$(SIM) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
